//--- logic/link_cfg_pkg.sv
// Link geometry shared by the transmitter and its testbench
// Widths are in bits unless a name says bytes
// DEF_IOW must be a multiple of 8 and no wider than the packet

package link_cfg_pkg;

   //######################################################################
   // Default widths, passed down from the top level as parameters
   //######################################################################
   parameter int DEF_DW  = 128;  // Data field
   parameter int DEF_AW  = 64;   // Each address field
   parameter int DEF_CW  = 32;   // Command word
   parameter int DEF_IOW = 64;   // Link beat width

   // Credit counters, cumulative beats, wrap modulo 2^CRW
   parameter int CRW = 16;

   // Packet byte count, big enough for the full packet
   parameter int LENW = 12;

   // Packet order on the link, least significant first:
   //   cmd        CW bits, always sent
   //   dstaddr    AW bits
   //   srcaddr    AW bits
   //   data       DW bits, only the used low bytes
   // A packet is sent as the low packet_bytes of this word,
   // csr_iowidth bytes per beat, byte 0 on phy_txdata[7:0]

endpackage

//--- logic/umi_cmd_pkg.sv
// Command word fields and the opcodes the link sizer knows about
// Only opcode, size and len are decoded here
// Opcodes outside this list are sized as packets carrying data

package umi_cmd_pkg;

   //######################################################################
   // Field positions in the command word
   //######################################################################
   parameter int OPCODE_LSB = 0;
   parameter int OPCODE_W   = 5;   // cmd[4:0]
   parameter int SIZE_LSB   = 5;
   parameter int SIZE_W     = 3;   // cmd[7:5], bytes per word as 2^size
   parameter int LEN_LSB    = 8;
   parameter int LEN_W      = 8;   // cmd[15:8], words minus one

   //######################################################################
   // Opcodes
   //######################################################################
   // Requests are odd, responses even
   parameter logic [OPCODE_W-1:0] OPC_INVALID    = 5'h00;
   parameter logic [OPCODE_W-1:0] OPC_READ       = 5'h01;
   parameter logic [OPCODE_W-1:0] OPC_READ_RESP  = 5'h02;  // Returns data
   parameter logic [OPCODE_W-1:0] OPC_WRITE      = 5'h03;  // Carries data
   parameter logic [OPCODE_W-1:0] OPC_WRITE_RESP = 5'h04;
   parameter logic [OPCODE_W-1:0] OPC_RDMA       = 5'h07;
   parameter logic [OPCODE_W-1:0] OPC_USER0      = 5'h0B;
   parameter logic [OPCODE_W-1:0] OPC_FUTURE0    = 5'h0D;
   parameter logic [OPCODE_W-1:0] OPC_LINK       = 5'h0E;  // Link control, cmd only
   parameter logic [OPCODE_W-1:0] OPC_ERROR      = 5'h0F;

   // How much of the packet goes over the link
   typedef enum logic [1:0] {
      CLASS_CMD_ONLY  = 2'd0,  // Command word alone
      CLASS_NO_DATA   = 2'd1,  // Command and both addresses
      CLASS_WITH_DATA = 2'd2   // Header plus (len+1)<<size data bytes
   } pkt_class_t;

endpackage

//--- logic/pkt_sizer.sv
// Sizes one channel's packet from its command word, purely combinational
// Data length is capped at DW/8 bytes, longer bursts are cut there
// Unknown opcodes are treated as carrying data

`timescale 1ns/100ps

module pkt_sizer
   import link_cfg_pkg::*;
   import umi_cmd_pkg::*;
#(
   parameter int DW = DEF_DW,
   parameter int AW = DEF_AW,
   parameter int CW = DEF_CW
)
(
   input  logic [CW-1:0]              cmd,           // Channel command word
   output logic [(DW+2*AW+CW)/8-1:0]  start_mask,    // Ones over used bytes
   output logic [LENW-1:0]            packet_bytes   // Bytes to send
);

   localparam int NB     = (DW+2*AW+CW)/8;  // Full packet in bytes
   localparam int CMD_B  = CW/8;
   localparam int HDR_B  = (2*AW+CW)/8;
   localparam int DATA_B = DW/8;

   logic [OPCODE_W-1:0] opcode;
   logic [SIZE_W-1:0]   size;
   logic [LEN_W-1:0]    len;
   logic [LEN_W+7:0]    raw_bytes;   // (len+1)<<7 still fits
   logic [LENW-1:0]     data_bytes;
   pkt_class_t          pkt_class;

   assign opcode = cmd[OPCODE_LSB +: OPCODE_W];
   assign size   = cmd[SIZE_LSB +: SIZE_W];
   assign len    = cmd[LEN_LSB +: LEN_W];

   // Data length in bytes, clipped to the data field
   always_comb
   begin
      raw_bytes  = (LEN_W+8)'(len) + 1'b1;
      raw_bytes  = raw_bytes << size;
      data_bytes = (raw_bytes > DATA_B) ? LENW'(DATA_B) : LENW'(raw_bytes);
   end

   // Small opcode classifier
   always_comb
   begin
      case (opcode)
         OPC_INVALID, OPC_LINK:           pkt_class = CLASS_CMD_ONLY;
         OPC_READ, OPC_RDMA, OPC_ERROR,
         OPC_WRITE_RESP, OPC_USER0,
         OPC_FUTURE0:                     pkt_class = CLASS_NO_DATA;
         default:                         pkt_class = CLASS_WITH_DATA;
      endcase
   end

   always_comb
   begin
      case (pkt_class)
         CLASS_CMD_ONLY: packet_bytes = LENW'(CMD_B);
         CLASS_NO_DATA:  packet_bytes = LENW'(HDR_B);
         default:        packet_bytes = LENW'(HDR_B) + data_bytes;
      endcase
   end

   // Ones over the low packet_bytes, packet_bytes never exceeds NB
   assign start_mask = ~({NB{1'b1}} << packet_bytes);

endmodule

//--- logic/credit_ctrl.sv
// Beat credits per channel, counted against cumulative remote grants
// Grants and counters wrap modulo 2^CRW, so at most 2^CRW-1 beats outstanding
// csr_iowidth must be nonzero while traffic flows

`timescale 1ns/100ps

module credit_ctrl
   import link_cfg_pkg::*;
(
   input  logic             clk,
   input  logic             nreset,
   input  logic [7:0]       csr_iowidth,     // Bytes per beat
   input  logic             beat_req,        // Request beat on the link
   input  logic             beat_resp,       // Response beat on the link
   input  logic [CRW-1:0]   rmt_crdt_req,    // Cumulative grant, request
   input  logic [CRW-1:0]   rmt_crdt_resp,   // Cumulative grant, response
   input  logic [LENW-1:0]  req_bytes,       // Pending request size
   input  logic [LENW-1:0]  resp_bytes,      // Pending response size
   output logic             req_credit_ok,
   output logic             resp_credit_ok
);

   logic [CRW-1:0] tx_crdt_req;    // Request beats sent so far
   logic [CRW-1:0] tx_crdt_resp;   // Response beats sent so far

   //######################################################################
   // Sent-beat counters
   //######################################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         tx_crdt_req  <= '0;
         tx_crdt_resp <= '0;
      end
      else
      begin
         if (beat_req)
            tx_crdt_req <= tx_crdt_req + 1'b1;    // Wraps with the grant
         if (beat_resp)
            tx_crdt_resp <= tx_crdt_resp + 1'b1;
      end
   end

   //######################################################################
   // Sufficiency check
   //######################################################################
   // A new packet can only be taken on the last beat of the one in flight,
   // and that beat is not in the counter yet, so it is taken off here
   function automatic logic enough(input logic [CRW-1:0]  grant,
                                   input logic [CRW-1:0]  sent,
                                   input logic            beat,
                                   input logic [LENW-1:0] bytes,
                                   input logic [7:0]      width);
      logic [CRW-1:0]   avail;
      logic [CRW+7:0]   avail_bytes;
      avail       = grant - sent - CRW'(beat);                // Modulo 2^CRW
      avail_bytes = (CRW+8)'(avail) * (CRW+8)'(width);
      // Same as avail >= ceil(bytes/width), no divider needed
      return avail_bytes >= (CRW+8)'(bytes);
   endfunction

   assign req_credit_ok  = enough(rmt_crdt_req, tx_crdt_req, beat_req,
                                  req_bytes, csr_iowidth);
   assign resp_credit_ok = enough(rmt_crdt_resp, tx_crdt_resp, beat_resp,
                                  resp_bytes, csr_iowidth);

endmodule

//--- logic/tx_arbiter.sv
// Picks which channel loads the serializer this cycle, combinational
// Response always wins over request when both are eligible
// Readies follow valids, so a channel never sees ready without valid

`timescale 1ns/100ps

module tx_arbiter
(
   input  logic csr_en,              // Link transmit enable
   input  logic phy_txrdy,           // Phy can take a new packet
   input  logic load_ok,             // Serializer idle or on last beat
   input  logic umi_req_in_valid,
   input  logic umi_resp_in_valid,
   input  logic req_credit_ok,       // Remote has room for request
   input  logic resp_credit_ok,      // Remote has room for response
   output logic umi_req_in_ready,
   output logic umi_resp_in_ready,
   output logic load,                // Capture selected packet
   output logic load_resp            // Selected packet is a response
);

   logic link_open;   // Conditions shared by both channels
   logic req_elig;
   logic resp_elig;

   //######################################################################
   // Eligibility
   //######################################################################
   // phy_txrdy only matters here, a packet already started runs to the end
   assign link_open = csr_en & phy_txrdy & load_ok;

   assign resp_elig = umi_resp_in_valid & resp_credit_ok & link_open;
   assign req_elig  = umi_req_in_valid  & req_credit_ok  & link_open;

   //######################################################################
   // Priority select
   //######################################################################
   assign umi_resp_in_ready = resp_elig;
   assign umi_req_in_ready  = req_elig & ~resp_elig;  // Request waits

   assign load      = resp_elig | req_elig;
   assign load_resp = resp_elig;  // Tag for credit accounting and the mux

endmodule

//--- logic/tx_serializer.sv
// Streams one packet at a time, LSB byte first, csr_iowidth bytes per beat
// csr_iowidth must stay within 1..IOW/8 and only change while idle
// Bytes above csr_iowidth on phy_txdata are don't-care

`timescale 1ns/100ps

module tx_serializer
   import link_cfg_pkg::*;
#(
   parameter int DW  = DEF_DW,
   parameter int AW  = DEF_AW,
   parameter int CW  = DEF_CW,
   parameter int IOW = DEF_IOW
)
(
   input  logic                       clk,
   input  logic                       nreset,
   input  logic [7:0]                 csr_iowidth,  // Bytes per beat
   input  logic                       load,         // Take pkt_in this cycle
   input  logic                       load_resp,    // pkt_in is a response
   input  logic [DW+2*AW+CW-1:0]      pkt_in,       // {data,src,dst,cmd}
   input  logic [(DW+2*AW+CW)/8-1:0]  start_mask,   // Used bytes of pkt_in
   output logic [IOW-1:0]             phy_txdata,
   output logic                       phy_txvld,
   output logic                       beat_req,     // Request beat sent
   output logic                       beat_resp,    // Response beat sent
   output logic                       load_ok       // Room for next packet
);

   localparam int PW = DW+2*AW+CW;
   localparam int NB = PW/8;

   logic [PW-1:0]  shift_reg;   // Packet, next byte at bit 0
   logic [NB-1:0]  byte_vld;    // Bytes still to send
   logic [NB-1:0]  vld_next;    // Left after this beat
   logic           tag_resp;    // Packet in flight is a response

   assign vld_next = byte_vld >> csr_iowidth;

   //######################################################################
   // Control state
   //######################################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         byte_vld <= '0;
         tag_resp <= 1'b0;
      end
      else if (load)
      begin
         byte_vld <= start_mask;
         tag_resp <= load_resp;
      end
      else
         byte_vld <= vld_next;   // Drains to zero, then stays idle
   end

   //######################################################################
   // Packet shift register
   //######################################################################
   always_ff @(posedge clk)
   begin
      if (load)
         shift_reg <= pkt_in;
      else if (phy_txvld)
         shift_reg <= shift_reg >> {csr_iowidth, 3'b000};  // Bytes to bits
   end

   //######################################################################
   // Link side
   //######################################################################
   assign phy_txdata = shift_reg[IOW-1:0];
   assign phy_txvld  = |byte_vld;

   assign beat_req  = phy_txvld & ~tag_resp;
   assign beat_resp = phy_txvld &  tag_resp;

   // Idle, or this beat is the last one, so back to back with no gap
   assign load_ok = ~phy_txvld | ~(|vld_next);

endmodule

//--- logic/clink_tx.sv
// Link transmitter, request and response channels over one narrow link
// Response has priority, each packet needs its full beat count in credit
// csr_iowidth is in bytes per beat and only changes while the link is idle

`timescale 1ns/100ps

module clink_tx
   import link_cfg_pkg::*;
#(
   parameter int DW  = DEF_DW,
   parameter int AW  = DEF_AW,
   parameter int CW  = DEF_CW,
   parameter int IOW = DEF_IOW
)
(
   input  logic            clk,
   input  logic            nreset,
   input  logic            csr_en,           // Allow new packets
   input  logic [7:0]      csr_iowidth,      // 1..IOW/8 bytes per beat
   // Request channel
   input  logic            umi_req_in_valid,
   input  logic [CW-1:0]   umi_req_in_cmd,
   input  logic [AW-1:0]   umi_req_in_dstaddr,
   input  logic [AW-1:0]   umi_req_in_srcaddr,
   input  logic [DW-1:0]   umi_req_in_data,
   output logic            umi_req_in_ready,
   // Response channel
   input  logic            umi_resp_in_valid,
   input  logic [CW-1:0]   umi_resp_in_cmd,
   input  logic [AW-1:0]   umi_resp_in_dstaddr,
   input  logic [AW-1:0]   umi_resp_in_srcaddr,
   input  logic [DW-1:0]   umi_resp_in_data,
   output logic            umi_resp_in_ready,
   // Link
   output logic [IOW-1:0]  phy_txdata,
   output logic            phy_txvld,
   input  logic            phy_txrdy,        // Gates new packets only
   // Remote grants, cumulative beats
   input  logic [CRW-1:0]  rmt_crdt_req,
   input  logic [CRW-1:0]  rmt_crdt_resp
);

   localparam int PW = DW+2*AW+CW;

   logic [PW/8-1:0]  req_start_mask;
   logic [PW/8-1:0]  resp_start_mask;
   logic [LENW-1:0]  req_bytes;
   logic [LENW-1:0]  resp_bytes;
   logic             req_credit_ok;
   logic             resp_credit_ok;
   logic             load;
   logic             load_resp;
   logic             load_ok;
   logic             beat_req;
   logic             beat_resp;
   logic [PW-1:0]    pkt_sel;      // Packet picked by the arbiter
   logic [PW/8-1:0]  mask_sel;

   //######################################################################
   // Sizing and credit
   //######################################################################
   pkt_sizer #(.DW(DW), .AW(AW), .CW(CW)) i_size_req (
      .cmd          (umi_req_in_cmd),
      .start_mask   (req_start_mask),
      .packet_bytes (req_bytes)
   );

   pkt_sizer #(.DW(DW), .AW(AW), .CW(CW)) i_size_resp (
      .cmd          (umi_resp_in_cmd),
      .start_mask   (resp_start_mask),
      .packet_bytes (resp_bytes)
   );

   credit_ctrl i_credit (
      .clk            (clk),
      .nreset         (nreset),
      .csr_iowidth    (csr_iowidth),
      .beat_req       (beat_req),
      .beat_resp      (beat_resp),
      .rmt_crdt_req   (rmt_crdt_req),
      .rmt_crdt_resp  (rmt_crdt_resp),
      .req_bytes      (req_bytes),
      .resp_bytes     (resp_bytes),
      .req_credit_ok  (req_credit_ok),
      .resp_credit_ok (resp_credit_ok)
   );

   //######################################################################
   // Arbitration and payload select
   //######################################################################
   tx_arbiter i_arbiter (
      .csr_en            (csr_en),
      .phy_txrdy         (phy_txrdy),
      .load_ok           (load_ok),
      .umi_req_in_valid  (umi_req_in_valid),
      .umi_resp_in_valid (umi_resp_in_valid),
      .req_credit_ok     (req_credit_ok),
      .resp_credit_ok    (resp_credit_ok),
      .umi_req_in_ready  (umi_req_in_ready),
      .umi_resp_in_ready (umi_resp_in_ready),
      .load              (load),
      .load_resp         (load_resp)
   );

   // Packet order, cmd in the low bits
   assign pkt_sel  = load_resp ?
                     {umi_resp_in_data, umi_resp_in_srcaddr, umi_resp_in_dstaddr,
                      umi_resp_in_cmd} :
                     {umi_req_in_data, umi_req_in_srcaddr, umi_req_in_dstaddr,
                      umi_req_in_cmd};
   assign mask_sel = load_resp ? resp_start_mask : req_start_mask;

   tx_serializer #(.DW(DW), .AW(AW), .CW(CW), .IOW(IOW)) i_serializer (
      .clk         (clk),
      .nreset      (nreset),
      .csr_iowidth (csr_iowidth),
      .load        (load),
      .load_resp   (load_resp),
      .pkt_in      (pkt_sel),
      .start_mask  (mask_sel),
      .phy_txdata  (phy_txdata),
      .phy_txvld   (phy_txvld),
      .beat_req    (beat_req),
      .beat_resp   (beat_resp),
      .load_ok     (load_ok)
   );

endmodule

//--- test/clink_tx_props.sv
// Handshake and reset checks on the transmitter ports
// Bound into every clink_tx instance

`timescale 1ns/100ps

module clink_tx_props
(
   input logic clk,
   input logic nreset,
   input logic umi_req_in_valid,
   input logic umi_req_in_ready,
   input logic umi_resp_in_valid,
   input logic umi_resp_in_ready,
   input logic phy_txvld
);

   // One channel per cycle
   one_ready_a: assert property (@(posedge clk) disable iff (!nreset)
                                 !(umi_req_in_ready && umi_resp_in_ready))
      else $error("Request and response ready high in the same cycle");

   // Ready only ever follows valid
   req_rdy_vld_a: assert property (@(posedge clk) disable iff (!nreset)
                                   umi_req_in_ready |-> umi_req_in_valid)
      else $error("umi_req_in_ready high without umi_req_in_valid");

   resp_rdy_vld_a: assert property (@(posedge clk) disable iff (!nreset)
                                    umi_resp_in_ready |-> umi_resp_in_valid)
      else $error("umi_resp_in_ready high without umi_resp_in_valid");

   // Async reset clears the serializer at once
   rst_idle_a: assert property (@(posedge clk) !nreset |-> !phy_txvld)
      else $error("phy_txvld high while nreset is held low");

endmodule

bind clink_tx clink_tx_props i_props (
   .clk               (clk),
   .nreset            (nreset),
   .umi_req_in_valid  (umi_req_in_valid),
   .umi_req_in_ready  (umi_req_in_ready),
   .umi_resp_in_valid (umi_resp_in_valid),
   .umi_resp_in_ready (umi_resp_in_ready),
   .phy_txvld         (phy_txvld)
);

//--- test/tb_clink_tx.sv
// Random traffic on both channels, link bytes checked against a model
// Widths are the package defaults, csr_iowidth steps through 1, 2, 4 and 8
// Expected readies are rebuilt from grants, the beat tally and the link state

`timescale 1ns/100ps

module tb_clink_tx
   import link_cfg_pkg::*;
   import umi_cmd_pkg::*;
();

   localparam int DW          = DEF_DW;
   localparam int AW          = DEF_AW;
   localparam int CW          = DEF_CW;
   localparam int IOW         = DEF_IOW;
   localparam int PW          = DW+2*AW+CW;
   localparam int PHASE_PKTS  = 100;                          // Taken per width
   localparam int MAX_BEATS   = PW/8;                         // Full packet, width 1
   localparam int WATCHDOG_NS = 4*PHASE_PKTS*MAX_BEATS*4*20;  // Stall margin 4

   logic clk, nreset, csr_en, phy_txrdy, phy_txvld;
   logic [7:0] csr_iowidth;
   logic umi_req_in_valid, umi_req_in_ready, umi_resp_in_valid, umi_resp_in_ready;
   logic [CW-1:0] umi_req_in_cmd, umi_resp_in_cmd;
   logic [AW-1:0] umi_req_in_dstaddr, umi_req_in_srcaddr;
   logic [AW-1:0] umi_resp_in_dstaddr, umi_resp_in_srcaddr;
   logic [DW-1:0] umi_req_in_data, umi_resp_in_data;
   logic [IOW-1:0] phy_txdata;
   logic [CRW-1:0] rmt_crdt_req, rmt_crdt_resp;

   logic [PW-1:0]  req_gen_q[$];    // Driven, not yet taken
   logic [PW-1:0]  resp_gen_q[$];
   logic [7:0]     exp_bytes[$];    // Link bytes still to come
   logic [CRW-1:0] tally_req, tally_resp;  // Beats of every accepted packet
   int beats_left, bytes_left;      // Packet in flight
   int stall_req, stall_resp;       // Grant stall countdowns
   int errors, accepted, beats_seen, prio_cnt, capped_cnt, b2b_cnt;
   int class_cnt[3];
   bit gen_on;                      // New packets allowed

   clink_tx #(.DW(DW), .AW(AW), .CW(CW), .IOW(IOW)) i_dut (.*);

   always #10 clk = ~clk;   // 20 ns

   //######################################################################
   // Reference rules for packet size
   //######################################################################
   function automatic logic [OPCODE_W-1:0] pick_opcode(input int k);
      case (k)
         0:       return OPC_INVALID;
         1:       return OPC_LINK;
         2:       return OPC_READ;
         3:       return OPC_RDMA;
         4:       return OPC_ERROR;
         5:       return OPC_WRITE_RESP;
         6:       return OPC_USER0;
         7:       return OPC_FUTURE0;
         8:       return OPC_WRITE;
         default: return OPC_READ_RESP;
      endcase
   endfunction

   // 0 command only, 1 header only, 2 header and data
   function automatic int packet_class(input logic [CW-1:0] cmd);
      logic [OPCODE_W-1:0] opc;
      opc = cmd[OPCODE_LSB +: OPCODE_W];
      if (opc == OPC_INVALID || opc == OPC_LINK)
         return 0;
      if (opc inside {OPC_READ, OPC_RDMA, OPC_ERROR, OPC_WRITE_RESP, OPC_USER0,
                      OPC_FUTURE0})
         return 1;
      return 2;
   endfunction

   function automatic int raw_data_len(input logic [CW-1:0] cmd);
      return (int'(cmd[LEN_LSB +: LEN_W]) + 1) << cmd[SIZE_LSB +: SIZE_W];
   endfunction

   function automatic int packet_len(input logic [CW-1:0] cmd);
      int raw;
      raw = raw_data_len(cmd);
      case (packet_class(cmd))
         0:       return CW/8;
         1:       return (2*AW+CW)/8;
         default: return (2*AW+CW)/8 + ((raw > DW/8) ? DW/8 : raw);  // Capped
      endcase
   endfunction

   function automatic int beats_for(input int bytes, input int w);
      return (bytes + w - 1) / w;
   endfunction

   function automatic bit credit_enough(input logic [CRW-1:0] grant,
                                        input logic [CRW-1:0] used, input int beats);
      logic [CRW-1:0] avail;
      avail = grant - used;   // Modulo 2^CRW
      return int'(avail) >= beats;
   endfunction

   function automatic logic [PW-1:0] random_packet();
      logic [CW-1:0] cmd;
      logic [AW-1:0] dst;
      logic [AW-1:0] src;
      logic [DW-1:0] data;
      cmd = $urandom;
      cmd[OPCODE_LSB +: OPCODE_W] = pick_opcode($urandom % 10);
      if ($urandom % 2)
      begin
         cmd[LEN_LSB +: LEN_W]   = LEN_W'($urandom % 4);   // Short burst, uncapped
         cmd[SIZE_LSB +: SIZE_W] = SIZE_W'($urandom % 3);
      end
      dst  = {$urandom, $urandom};
      src  = {$urandom, $urandom};
      data = {$urandom, $urandom, $urandom, $urandom};
      return {data, src, dst, cmd};
   endfunction

   //######################################################################
   // Model side of one channel transfer
   //######################################################################
   task automatic take_packet(input bit resp, input int w, input bit on_beat);
      logic [PW-1:0] pkt;
      int            len;
      if (beats_left != 0)
      begin
         $display("Time %0t: packet taken with %0d beats of the last one unsent",
                  $time, beats_left);
         errors++;
      end
      if (resp)
         pkt = resp_gen_q.pop_front();
      else
         pkt = req_gen_q.pop_front();
      len = packet_len(pkt[CW-1:0]);
      for (int i = 0; i < len; i++)
         exp_bytes.push_back(pkt[8*i +: 8]);   // LSB byte first
      bytes_left = len;
      beats_left = beats_for(len, w);
      if (resp)
         tally_resp <= tally_resp + CRW'(beats_left);
      else
         tally_req <= tally_req + CRW'(beats_left);
      class_cnt[packet_class(pkt[CW-1:0])]++;
      if (packet_class(pkt[CW-1:0]) == 2 && raw_data_len(pkt[CW-1:0]) > DW/8)
         capped_cnt++;
      if (on_beat)
         b2b_cnt++;   // No gap after the last packet
      accepted++;
   endtask

   //######################################################################
   // Model and checks, on values from before the edge
   //######################################################################
   always @(posedge clk)
   begin
      int w, n;
      bit link_m, req_elig, exp_req_rdy, exp_resp_rdy, on_beat;
      logic [7:0] exp_b;
      w = csr_iowidth;
      if (!nreset)
      begin
         if (phy_txvld !== 1'b0)
         begin
            $display("[ERROR] %0t: phy_txvld expected 0 actual %b", $time, phy_txvld);
            errors++;
         end
         if (umi_req_in_ready !== 1'b0 || umi_resp_in_ready !== 1'b0)
         begin
            $display("Time %0t: a channel ready is high during reset", $time);
            errors++;
         end
         exp_bytes.delete();
         beats_left = 0;
         bytes_left = 0;
         tally_req  <= '0;   // Counters start from zero
         tally_resp <= '0;
      end
      else
      begin
         link_m       = csr_en && phy_txrdy && (beats_left <= 1);  // Idle or last beat
         exp_resp_rdy = umi_resp_in_valid && link_m && credit_enough(rmt_crdt_resp,
                        tally_resp, beats_for(packet_len(umi_resp_in_cmd), w));
         req_elig     = umi_req_in_valid && link_m && credit_enough(rmt_crdt_req,
                        tally_req, beats_for(packet_len(umi_req_in_cmd), w));
         exp_req_rdy  = req_elig && !exp_resp_rdy;  // Response first
         if (umi_resp_in_ready !== exp_resp_rdy)
         begin
            $display("[ERROR] %0t: umi_resp_in_ready expected %b actual %b",
                     $time, exp_resp_rdy, umi_resp_in_ready);
            errors++;
         end
         if (umi_req_in_ready !== exp_req_rdy)
         begin
            $display("[ERROR] %0t: umi_req_in_ready expected %b actual %b",
                     $time, exp_req_rdy, umi_req_in_ready);
            errors++;
         end
         if (phy_txvld !== (beats_left != 0))
         begin
            $display("[ERROR] %0t: phy_txvld expected %b actual %b",
                     $time, beats_left != 0, phy_txvld);
            errors++;
         end
         on_beat = (phy_txvld === 1'b1);
         if (on_beat)
         begin
            n = (bytes_left < w) ? bytes_left : w;   // Last beat may be short
            for (int i = 0; i < n; i++)
            begin
               exp_b = exp_bytes.pop_front();
               if (phy_txdata[8*i +: 8] !== exp_b)
               begin
                  $display("[ERROR] %0t: phy_txdata[%0d:%0d] expected %h actual %h",
                           $time, 8*i+7, 8*i, exp_b, phy_txdata[8*i +: 8]);
                  errors++;
               end
            end
            bytes_left -= n;
            if (beats_left > 0)
               beats_left--;
            beats_seen++;
         end
         if (umi_resp_in_valid && umi_resp_in_ready)
         begin
            if (req_elig)
               prio_cnt++;   // Both eligible, response won
            take_packet(1'b1, w, on_beat);
         end
         else if (umi_req_in_valid && umi_req_in_ready)
            take_packet(1'b0, w, on_beat);
      end
   end

   //######################################################################
   // Stimulus, driven on the rising edge
   //######################################################################
   always @(posedge clk)
   begin
      logic [PW-1:0]  pkt;
      logic [CRW-1:0] avail;
      if (nreset)
      begin
         phy_txrdy <= ($urandom % 100) < 80;
         csr_en    <= ($urandom % 100) < 90;
         // New request only once the last one is gone
         if (!umi_req_in_valid || umi_req_in_ready)
         begin
            if (gen_on && ($urandom % 100) < 55)
            begin
               pkt = random_packet();
               req_gen_q.push_back(pkt);
               umi_req_in_cmd     <= pkt[CW-1:0];
               umi_req_in_dstaddr <= pkt[CW +: AW];
               umi_req_in_srcaddr <= pkt[CW+AW +: AW];
               umi_req_in_data    <= pkt[CW+2*AW +: DW];
               umi_req_in_valid   <= 1'b1;
            end
            else
               umi_req_in_valid <= 1'b0;
         end
         if (!umi_resp_in_valid || umi_resp_in_ready)
         begin
            if (gen_on && ($urandom % 100) < 55)
            begin
               pkt = random_packet();
               resp_gen_q.push_back(pkt);
               umi_resp_in_cmd     <= pkt[CW-1:0];
               umi_resp_in_dstaddr <= pkt[CW +: AW];
               umi_resp_in_srcaddr <= pkt[CW+AW +: AW];
               umi_resp_in_data    <= pkt[CW+2*AW +: DW];
               umi_resp_in_valid   <= 1'b1;
            end
            else
               umi_resp_in_valid <= 1'b0;
         end
         // Grants creep up, stall now and then
         avail = rmt_crdt_req - tally_req;
         if (stall_req > 0)
            stall_req--;
         else if (($urandom % 100) < 2)
            stall_req = 20 + $urandom % 60;
         else if (avail < 100)
            rmt_crdt_req <= rmt_crdt_req + CRW'($urandom % 3);
         avail = rmt_crdt_resp - tally_resp;
         if (stall_resp > 0)
            stall_resp--;
         else if (($urandom % 100) < 2)
            stall_resp = 20 + $urandom % 60;
         else if (avail < 100)
            rmt_crdt_resp <= rmt_crdt_resp + CRW'($urandom % 3);
      end
   end

   //######################################################################
   // Phases and final report
   //######################################################################
   initial
   begin
      int widths[4];
      void'($urandom(17666));
      widths = '{1, 2, 4, 8};
      clk = 1'b0;
      nreset = 1'b0;
      csr_en = 1'b0;
      csr_iowidth = 8'd1;
      phy_txrdy = 1'b0;
      umi_req_in_valid = 1'b0;
      umi_req_in_cmd = '0;
      umi_req_in_dstaddr = '0;
      umi_req_in_srcaddr = '0;
      umi_req_in_data = '0;
      umi_resp_in_valid = 1'b0;
      umi_resp_in_cmd = '0;
      umi_resp_in_dstaddr = '0;
      umi_resp_in_srcaddr = '0;
      umi_resp_in_data = '0;
      rmt_crdt_req = '0;
      rmt_crdt_resp = '0;
      gen_on = 1'b0;
      repeat (4) @(posedge clk);
      nreset <= 1'b1;
      for (int ph = 0; ph < 4; ph++)
      begin
         csr_iowidth <= 8'(widths[ph]);   // Link idle here
         gen_on      <= 1'b1;
         wait (accepted >= (ph+1)*PHASE_PKTS);
         @(posedge clk);
         gen_on <= 1'b0;
         repeat (2) @(posedge clk);
         while (umi_req_in_valid || umi_resp_in_valid || phy_txvld)
            @(posedge clk);   // Drain held packets
      end
      repeat (5) @(posedge clk);
      if (exp_bytes.size() != 0)
      begin
         $display("%0d expected link bytes never arrived", exp_bytes.size());
         errors++;
      end
      if (prio_cnt == 0 || capped_cnt == 0 || b2b_cnt == 0)
      begin
         $display("Traffic missed priority, capped length or back to back cases");
         errors++;
      end
      if (class_cnt[0] == 0 || class_cnt[1] == 0 || class_cnt[2] == 0)
      begin
         $display("Traffic missed one of the three packet classes");
         errors++;
      end
      $display("Packets %0d (cmd %0d, hdr %0d, data %0d, capped %0d), beats %0d, errors %0d",
               accepted, class_cnt[0], class_cnt[1], class_cnt[2], capped_cnt,
               beats_seen, errors);
      if (errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns with %0d packets taken",
               WATCHDOG_NS, accepted);
      $display("Verification failed");
      $finish;
   end

endmodule

//--- clink_tx.f
logic/link_cfg_pkg.sv
logic/umi_cmd_pkg.sv
logic/pkt_sizer.sv
logic/credit_ctrl.sv
logic/tx_arbiter.sv
logic/tx_serializer.sv
logic/clink_tx.sv
test/clink_tx_props.sv
test/tb_clink_tx.sv
